/* Bender.yml */
package:
  name: cps2_crypt

sources:
  - include_dirs:
      - src
    files:
      - src/cps2_crypt_pkg.sv
      - src/cps2_keyload.sv
      - src/cps2_feistel.sv
      - src/cps2_fetch_decrypt.sv
      - src/cps2_crypt_top.sv

  - target: simulation
    include_dirs:
      - src
    files:
      - sim/cps2_crypt_tb.sv

/* cps2_crypt.f */
+incdir+src
src/cps2_crypt_pkg.sv
src/cps2_keyload.sv
src/cps2_feistel.sv
src/cps2_fetch_decrypt.sv
src/cps2_crypt_top.sv
sim/cps2_crypt_tb.sv

/* sim/cps2_crypt_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cps2_crypt_settings.svh"

module cps2_crypt_tb;

    import cps2_crypt_pkg::*;

    localparam int NUM_FETCH = 300;
    localparam int PRE_FETCH = 20;   // Fetches sent before the key load completes
    localparam int TIMEOUT   = `CPS2_KEY_BYTES * 4 + NUM_FETCH * 2 + 200;

    logic        clk;
    logic        rst;
    half_t       din;
    logic        din_we;
    logic        fetch_valid;
    addr_t       fetch_addr;
    word_t       fetch_data;
    logic        out_valid;
    word_t       out_data;
    logic        key_ready;

    int          cycle;       // Cycles since time zero
    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    key_t        ref_key;     // Key and bound worked out from the bytes sent
    range_t      ref_rng;
    word_t       exp_q [$];   // Expected words in fetch order
    int          arr_q [$];   // Cycle in which each strobe was high

    cps2_crypt_top UUT (
        .clk         (clk),
        .rst         (rst),
        .din         (din),
        .din_we      (din_we),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .key_ready   (key_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Counter moves at every rising edge, so it reads the old value at that edge
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT);
            $display("Simulation failed");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (rand_next() >> 8) % n;   // Low LCG bits have short periods
    endfunction

    function automatic half_t rotl8(input half_t x, input int s);
        logic [15:0] d;
        d = {x, x} << s;
        return d[15:8];
    endfunction

    // Round function of round n applied to right half r
    function automatic half_t round_f(input half_t r, input key_t k, input half_t a, input int n);
        half_t t;
        t = r ^ k[16*n +: 8] ^ a;               // Key byte 2n with the low address byte
        return rotl8(t, n + 1) ^ k[16*n+8 +: 8];
    endfunction

    function automatic word_t decrypt_word(input word_t c, input key_t k, input half_t a);
        half_t l;
        half_t r;
        half_t old_l;
        l = c[15:8];
        r = c[7:0];
        for (int n = 0; n < `CPS2_ROUNDS; n++) begin
            old_l = l;
            l     = r;
            r     = old_l ^ round_f(r, k, a, n);
        end
        return {l, r};
    endfunction

    // Undoes the rounds from the last one down
    function automatic word_t encrypt_word(input word_t p, input key_t k, input half_t a);
        half_t l;
        half_t r;
        half_t old_r;
        l = p[15:8];
        r = p[7:0];
        for (int n = `CPS2_ROUNDS - 1; n >= 0; n--) begin
            old_r = l;                          // Right half before round n
            l     = r ^ round_f(old_r, k, a, n);
            r     = old_r;
        end
        return {l, r};
    endfunction

    // Lane rule, output lane j from the top draws on raw lane j from the bottom
    function automatic cfg_t scramble_cfg(input cfg_t raw);
        cfg_t cfg;
        int   top;
        int   base;
        cfg = '0;
        for (int j = 0; j < $bits(cfg_t) / 16; j++) begin
            top  = $bits(cfg_t) - 1 - 16 * j;
            base = 16 * j;
            for (int k = 0; k < 6; k++) begin
                cfg[top - k] = raw[base + 10 + k];
            end
            for (int k = 0; k < 8; k++) begin
                cfg[top - 6 - k] = raw[base + k];
            end
            cfg[top - 14] = raw[(base + $bits(cfg_t) - 8) % $bits(cfg_t)];
            cfg[top - 15] = raw[(base + $bits(cfg_t) - 7) % $bits(cfg_t)];
        end
        return cfg;
    endfunction

    function automatic key_t key_from_cfg(input cfg_t cfg);
        key_t k;
        for (int q = 0; q < 4; q++) begin
            k[63 - 16*q -: 16] = cfg[16*q +: 16];   // Lowest lane lands on top
        end
        return k;
    endfunction

    function automatic word_t expected_out(input addr_t a, input word_t d, input logic ready);
        if (ready && a[22:7] < ref_rng) begin
            return decrypt_word(d, ref_key, a[7:0]);
        end
        return d;
    endfunction

    // ----------------------------------------------------------
    // Stimulus and checks
    // ----------------------------------------------------------

    task automatic check_ready(input int taken);
        logic want;
        want = (taken >= `CPS2_KEY_BYTES);
        checks++;
        if (key_ready !== want) begin
            errors++;
            $display("error %0t: key_ready %b after %0d bytes, expected %b, loader in %s",
                     $time, key_ready, taken, want, UUT.u_keyload.state.name());
        end
    endtask

    // Each strobe stays high for three edges and drops for one
    task automatic load_key(input cfg_t raw, input int first, input int count);
        int taken;
        taken = first;
        for (int i = first; i < first + count; i++) begin
            @(posedge clk);
            din    <= raw[8*i +: 8];
            din_we <= 1'b1;
            @(negedge clk);
            check_ready(taken);
            @(posedge clk);                 // Byte taken here
            taken++;
            @(negedge clk);
            check_ready(taken);
            repeat (2) @(posedge clk);
            din_we <= 1'b0;
        end
    endtask

    task automatic send_fetch(input addr_t a, input word_t d, input word_t exp_w);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= a;
        fetch_data  <= d;
        exp_q.push_back(exp_w);
        arr_q.push_back(cycle + 1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            fetch_valid <= 1'b0;
        end
    endtask

    // Every cycle either the oldest fetch is due or out_valid must stay low
    always @(negedge clk) begin
        if (exp_q.size() != 0 && arr_q[0] + `CPS2_LATENCY == cycle) begin
            checks++;
            if (out_valid !== 1'b1) begin
                errors++;
                $display("No output strobe at %0t for the fetch of cycle %0d", $time, arr_q[0]);
            end else if (out_data !== exp_q[0]) begin
                errors++;
                $display("error %0t: out_data %h, expected %h", $time, out_data, exp_q[0]);
            end
            void'(exp_q.pop_front());
            void'(arr_q.pop_front());
        end else if (out_valid !== 1'b0) begin
            errors++;
            $display("Unexpected output strobe at %0t in cycle %0d", $time, cycle);
        end
    end

    initial begin
        cfg_t   raw;
        cfg_t   cfg;
        addr_t  a;
        word_t  d;
        word_t  plain;
        range_t hi;
        range_t part_rng;
        range_t edges [5];
        int     sel;

        rst         = 1'b1;
        din         = '0;
        din_we      = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        fetch_data  = '0;
        lcg_state   = 32'd38;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_ready(0);

        for (int i = 0; i < `CPS2_KEY_BYTES; i++) begin
            raw[8*i +: 8] = half_t'(rand_next() >> 24);
        end
        cfg      = scramble_cfg(raw);
        ref_key  = key_from_cfg(cfg);
        ref_rng  = cfg[79:64];
        cfg      = scramble_cfg(raw << 8);   // Register contents one byte short of a full key
        part_rng = cfg[79:64];
        load_key(raw, 0, `CPS2_KEY_BYTES - 1);

        // The last key byte is still missing so even words below the partial bound pass unchanged
        for (int i = 0; i < PRE_FETCH; i++) begin
            if (part_rng != 0 && rand_below(4) != 0) begin
                hi = range_t'(rand_below(part_rng));
            end else begin
                hi = range_t'(rand_next() >> 16);
            end
            a = {hi, 7'(rand_next() >> 25)};
            d = word_t'(rand_next() >> 16);
            send_fetch(a, d, expected_out(a, d, 1'b0));
            if (rand_below(3) == 0) begin
                idle_cycles(1);
            end
        end
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end

        load_key(raw, `CPS2_KEY_BYTES - 1, 1);
        @(negedge clk);
        checks++;
        if (UUT.u_keyload.key !== ref_key || UUT.u_keyload.addr_rng !== ref_rng) begin
            errors++;
            $display("error %0t: key %h bound %h, expected key %h bound %h", $time,
                     UUT.u_keyload.key, UUT.u_keyload.addr_rng, ref_key, ref_rng);
        end

        // First five fetches walk the bound edges, the rest are mixed
        edges = '{16'h0000, ref_rng - 16'd1, ref_rng, ref_rng + 16'd1, 16'hFFFF};
        for (int i = 0; i < NUM_FETCH - PRE_FETCH; i++) begin
            sel = (i < 5) ? 6 : int'(rand_below(8));
            if (sel < 4 && ref_rng != 0) begin
                hi    = range_t'(rand_below(ref_rng));
                a     = {hi, 7'(rand_next() >> 25)};
                plain = word_t'(rand_next() >> 16);
                d     = encrypt_word(plain, ref_key, a[7:0]);
                send_fetch(a, d, plain);   // Round trip through the DUT key
            end else begin
                if (sel < 6) begin
                    hi = range_t'(ref_rng + rand_below(32'd65536 - 32'(ref_rng)));
                end else begin
                    hi = edges[(i < 5) ? i : int'(rand_below(5))];
                end
                a = {hi, 7'(rand_next() >> 25)};
                d = word_t'(rand_next() >> 16);
                send_fetch(a, d, expected_out(a, d, 1'b1));
            end
            if (rand_below(4) == 0) begin
                idle_cycles(1 + rand_below(2));
            end
        end

        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);      // Catch any stray strobe
        @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/cps2_crypt_pkg.sv */
`default_nettype none

package cps2_crypt_pkg;

    // ----------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------

    typedef logic [159:0] cfg_t;    // Raw or scrambled configuration bits
    typedef logic [63:0]  key_t;    // Cipher key with two bytes per round
    typedef logic [15:0]  range_t;  // Upper bound on address bits 22 to 7
    typedef logic [22:0]  addr_t;   // Word address of a program fetch
    typedef logic [15:0]  word_t;   // Fetched opcode or data word
    typedef logic [7:0]   half_t;   // Feistel half, key byte or config byte

    // ----------------------------------------------------------
    // Key loader state machine
    // ----------------------------------------------------------

    // Nothing taken yet, partial load, full key present
    typedef enum logic [1:0] {
        LOAD_EMPTY   = 2'd0,
        LOAD_FILLING = 2'd1,
        LOAD_READY   = 2'd2
    } load_state_t;

endpackage

`default_nettype wire

/* src/cps2_crypt_settings.svh */
`ifndef CPS2_CRYPT_SETTINGS_SVH
`define CPS2_CRYPT_SETTINGS_SVH

// ----------------------------------------------------------
// Key loader
// ----------------------------------------------------------

// Bytes needed before the cipher key counts as loaded
`define CPS2_KEY_BYTES 20

// ----------------------------------------------------------
// Decrypter
// ----------------------------------------------------------

// Feistel rounds, one pipeline stage per round
`define CPS2_ROUNDS 4

// Cycles from fetch strobe to output strobe
// Stages beyond the round count only carry the word along
`define CPS2_LATENCY 4

`endif

/* src/cps2_crypt_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cps2_crypt_top (
    input  wire                   clk,
    input  wire                   rst,
    input  cps2_crypt_pkg::half_t din,          // Key byte
    input  wire                   din_we,
    input  wire                   fetch_valid,
    input  cps2_crypt_pkg::addr_t fetch_addr,
    input  cps2_crypt_pkg::word_t fetch_data,
    output logic                  out_valid,    // Fetch strobe delayed by the pipeline latency
    output cps2_crypt_pkg::word_t out_data,
    output logic                  key_ready
);

    import cps2_crypt_pkg::*;

    key_t   key;
    range_t addr_rng;

    // ----------------------------------------------------------
    // Key path
    // ----------------------------------------------------------

    cps2_keyload u_keyload (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .din_we    (din_we),
        .key       (key),
        .addr_rng  (addr_rng),
        .key_ready (key_ready)
    );

    // ----------------------------------------------------------
    // Fetch path
    // ----------------------------------------------------------

    cps2_fetch_decrypt u_fetch_decrypt (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .key         (key),
        .addr_rng    (addr_rng),
        .key_ready   (key_ready),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

/* src/cps2_feistel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cps2_crypt_settings.svh"

module cps2_feistel (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   in_valid,
    input  wire                   in_bypass,  // Word leaves the pipeline unchanged
    input  cps2_crypt_pkg::addr_t in_addr,
    input  cps2_crypt_pkg::word_t in_data,
    input  cps2_crypt_pkg::key_t  key,
    output logic                  out_valid,
    output cps2_crypt_pkg::word_t out_data
);

    import cps2_crypt_pkg::*;

    localparam int STAGES = `CPS2_LATENCY;  // At least one stage per round

    // Stage registers, index s holds the item after stage s
    logic  q_v [STAGES];
    logic  q_b [STAGES];
    half_t q_a [STAGES];  // Low address byte mixed into every round byte
    half_t q_l [STAGES];
    half_t q_r [STAGES];

    // ----------------------------------------------------------
    // Pipeline stages
    // ----------------------------------------------------------

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        logic  d_v;
        logic  d_b;
        half_t d_a;
        half_t d_l;
        half_t d_r;
        half_t n_l;  // Halves leaving this stage
        half_t n_r;

        // Stage 0 takes the fetch, later stages take the previous registers
        if (s == 0) begin : g_src_in
            assign d_v = in_valid;
            assign d_b = in_bypass;
            assign d_a = in_addr[7:0];
            assign d_l = in_data[15:8];
            assign d_r = in_data[7:0];
        end else begin : g_src_prev
            assign d_v = q_v[s-1];
            assign d_b = q_b[s-1];
            assign d_a = q_a[s-1];
            assign d_l = q_l[s-1];
            assign d_r = q_r[s-1];
        end

        if (s < `CPS2_ROUNDS) begin : g_round
            localparam int ROT = s + 1;  // Rotation grows by one bit per round
            half_t rk;
            half_t t;
            half_t f;

            assign rk = key[16*s +: 8] ^ d_a;                           // Key byte 2s with address
            assign t  = d_r ^ rk;
            assign f  = {t[7-ROT:0], t[7:8-ROT]} ^ key[16*s+8 +: 8];    // Then key byte 2s+1

            // Swap halves, the old left half absorbs the round function
            assign n_l = d_b ? d_l : d_r;
            assign n_r = d_b ? d_r : (d_l ^ f);
        end else begin : g_delay
            // Padding stage that only adds latency
            assign n_l = d_l;
            assign n_r = d_r;
        end

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                q_v[s] <= 1'b0;
            end else begin
                q_v[s] <= d_v;
            end
        end

        // Payload follows the valid bit without a reset
        always_ff @(posedge clk) begin
            q_b[s] <= d_b;
            q_a[s] <= d_a;
            q_l[s] <= n_l;
            q_r[s] <= n_r;
        end
    end

    // ----------------------------------------------------------
    // Output
    // ----------------------------------------------------------

    assign out_valid = q_v[STAGES-1];
    assign out_data  = {q_l[STAGES-1], q_r[STAGES-1]};  // Final left half on top

endmodule

`default_nettype wire

/* src/cps2_fetch_decrypt.sv */
`timescale 1ns/1ps
`default_nettype none

module cps2_fetch_decrypt (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    fetch_valid,  // One-cycle strobe per fetch
    input  cps2_crypt_pkg::addr_t  fetch_addr,
    input  cps2_crypt_pkg::word_t  fetch_data,
    input  cps2_crypt_pkg::key_t   key,
    input  cps2_crypt_pkg::range_t addr_rng,
    input  wire                    key_ready,
    output logic                   out_valid,
    output cps2_crypt_pkg::word_t  out_data
);

    import cps2_crypt_pkg::*;

    range_t addr_hi;   // Address bits compared against the bound
    logic   in_range;
    logic   bypass;

    // ----------------------------------------------------------
    // Range decision
    // ----------------------------------------------------------

    assign addr_hi  = fetch_addr[22:7];
    assign in_range = (addr_hi < addr_rng);  // Bound itself is already outside

    // Without a complete key nothing is decrypted
    assign bypass = ~key_ready | ~in_range;

    // ----------------------------------------------------------
    // Feistel pipeline
    // ----------------------------------------------------------

    // The decision travels with the word so a later key change cannot split it
    cps2_feistel u_feistel (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fetch_valid),
        .in_bypass (bypass),
        .in_addr   (fetch_addr),
        .in_data   (fetch_data),
        .key       (key),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

/* src/cps2_keyload.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cps2_crypt_settings.svh"

module cps2_keyload (
    input  wire                    clk,
    input  wire                    rst,
    input  cps2_crypt_pkg::half_t  din,       // Configuration byte
    input  wire                    din_we,    // Write strobe, one byte per rising edge
    output cps2_crypt_pkg::key_t   key,
    output cps2_crypt_pkg::range_t addr_rng,
    output logic                   key_ready
);

    import cps2_crypt_pkg::*;

    localparam int CFG_W = `CPS2_KEY_BYTES * 8;
    localparam int LANES = CFG_W / 16;                // 16-bit lanes in the configuration
    localparam int CNT_W = $clog2(`CPS2_KEY_BYTES + 1);

    logic             last_we;   // Strobe level seen at the previous edge
    logic             take;      // A new byte enters this cycle
    cfg_t             raw;       // Bytes in arrival order, first byte lowest
    wire cfg_t        cfg;       // Scrambled configuration
    logic [CNT_W-1:0] byte_cnt;
    load_state_t      state;
    load_state_t      state_nxt;

    // ----------------------------------------------------------
    // Byte capture
    // ----------------------------------------------------------

    // Only the rising edge of the strobe counts so a held strobe loads once
    assign take = din_we & ~last_we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_we <= 1'b0;
            raw     <= '0;
        end else begin
            last_we <= din_we;
            if (take) begin
                raw <= {din, raw[CFG_W-1:8]};  // New byte on top, older bytes move down
            end
        end
    end

    // ----------------------------------------------------------
    // Load tracking
    // ----------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            LOAD_EMPTY: begin
                if (take) begin
                    state_nxt = LOAD_FILLING;
                end
            end
            LOAD_FILLING: begin
                // The last byte of the key completes the load
                if (take && byte_cnt == CNT_W'(`CPS2_KEY_BYTES - 1)) begin
                    state_nxt = LOAD_READY;
                end
            end
            LOAD_READY: state_nxt = LOAD_READY;  // Later bytes still shift in
            default:    state_nxt = LOAD_EMPTY;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= LOAD_EMPTY;
            byte_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (take && state != LOAD_READY) begin
                byte_cnt <= byte_cnt + 1'b1;  // Stops counting once the key is complete
            end
        end
    end

    assign key_ready = (state == LOAD_READY);

    // ----------------------------------------------------------
    // Lane scramble
    // ----------------------------------------------------------

    // Output lane j is counted from the top and draws on raw lane j counted from the bottom
    for (genvar j = 0; j < LANES; j++) begin : g_lane
        localparam int OB = CFG_W - 1 - 16 * j;           // Top output bit of this lane
        localparam int RB = 16 * j;                       // Bottom raw bit of the source lane
        localparam int WB = (RB + CFG_W - 8) % CFG_W;     // Two bits borrowed from below

        // Raw bits 10 to 15 fill the top six, lower raw bit goes higher
        for (genvar k = 0; k < 6; k++) begin : g_top
            assign cfg[OB - k] = raw[RB + 10 + k];
        end

        // Raw bits 0 to 7 fill the middle eight
        for (genvar k = 0; k < 8; k++) begin : g_mid
            assign cfg[OB - 6 - k] = raw[RB + k];
        end

        assign cfg[OB - 14] = raw[WB];      // Wraps to the top byte for lane 0
        assign cfg[OB - 15] = raw[WB + 1];
    end

    // ----------------------------------------------------------
    // Key and range extraction
    // ----------------------------------------------------------

    // Low four lanes in reversed order, lowest lane at the top of the key
    assign key = {cfg[15:0], cfg[31:16], cfg[47:32], cfg[63:48]};

    assign addr_rng = cfg[79:64];  // Fifth lane from the bottom

endmodule

`default_nettype wire
